// File: rtl/matrix_pkg.sv
`default_nettype none

package matrix_pkg;

    typedef logic [1:0]  slot_t;    // Slot index
    typedef logic [2:0]  dim_t;     // Row or column count or index
    typedef logic [3:0]  elem_t;
    typedef logic [15:0] number_t;  // Saturates at all ones

    localparam int MAX_DIM   = 5;
    localparam int MAX_ELEM  = 9;
    localparam int NUM_SLOTS = 4;

    // 115200 baud from a 50 MHz clock
    localparam int CLKS_PER_BIT    = 434;
    localparam int ERR_HOLD_CYCLES = 25_000_000;  // Half a second

    localparam logic [7:0] ASCII_ZERO     = 8'h30;
    localparam logic [7:0] ASCII_SPACE    = 8'h20;
    localparam logic [7:0] ASCII_LF       = 8'h0A;
    localparam logic [7:0] ASCII_CR       = 8'h0D;
    localparam logic [7:0] ASCII_COMMA    = 8'h2C;
    localparam logic [7:0] ASCII_LBRACKET = 8'h5B;
    localparam logic [7:0] ASCII_RBRACKET = 8'h5D;

    typedef enum logic [1:0] {
        ENTRY_ROWS,
        ENTRY_COLS,
        ENTRY_ELEMS
    } entry_state_t;

    typedef enum logic [2:0] {
        PR_IDLE,
        PR_OPEN,
        PR_READ,
        PR_DIGIT,
        PR_SEP,
        PR_CLOSE,
        PR_LF
    } print_state_t;

endpackage

`default_nettype wire

// File: rtl/matrix_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// Entry controller to store
interface mat_wr_if;
    matrix_pkg::slot_t slot;
    matrix_pkg::dim_t  row;
    matrix_pkg::dim_t  col;
    matrix_pkg::elem_t data;
    logic              we;
    matrix_pkg::dim_t  dim_m;
    matrix_pkg::dim_t  dim_n;
    logic              dim_we;   // Also marks the slot's elements unwritten

    modport writer (
        output slot, row, col, data, we, dim_m, dim_n, dim_we
    );
    modport store (
        input slot, row, col, data, we, dim_m, dim_n, dim_we
    );
endinterface

// Printer to store with rdata one cycle after the address
interface mat_rd_if;
    matrix_pkg::slot_t slot;
    matrix_pkg::dim_t  row;
    matrix_pkg::dim_t  col;
    matrix_pkg::elem_t rdata;
    matrix_pkg::dim_t  dim_m;    // Follows slot directly
    matrix_pkg::dim_t  dim_n;

    modport printer (
        output slot, row, col,
        input  rdata, dim_m, dim_n
    );
    modport store (
        input  slot, row, col,
        output rdata, dim_m, dim_n
    );
endinterface

`default_nettype wire

// File: rtl/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rxd,
    output logic [7:0] rx_data,
    output logic       rx_valid
);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t state;
    logic      rxd_meta;
    logic      rxd_sync;
    logic      half_end;
    logic      bit_end;
    logic [2:0] bit_idx;
    logic [$clog2(matrix_pkg::CLKS_PER_BIT)-1:0] baud_cnt;

    assign half_end = (baud_cnt == matrix_pkg::CLKS_PER_BIT / 2 - 1);
    assign bit_end  = (baud_cnt == matrix_pkg::CLKS_PER_BIT - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rxd_meta <= 1'b1;  // Line idles high
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= RX_IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            baud_cnt <= baud_cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    baud_cnt <= '0;
                    if (!rxd_sync) state <= RX_START;
                end
                RX_START: if (half_end) begin
                    baud_cnt <= '0;
                    bit_idx  <= '0;
                    state    <= rxd_sync ? RX_IDLE : RX_DATA;  // High again means a glitch
                end
                RX_DATA: if (bit_end) begin
                    baud_cnt <= '0;
                    bit_idx  <= bit_idx + 1'b1;
                    if (bit_idx == 3'd7) state <= RX_STOP;
                end
                RX_STOP: if (bit_end) begin
                    rx_valid <= rxd_sync;  // Framing error drops the byte
                    state    <= RX_IDLE;
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_end) rx_data <= {rxd_sync, rx_data[7:1]};
    end

    a_rx_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        rx_valid |=> !rx_valid);

endmodule

`default_nettype wire

// File: rtl/number_parser.sv
`timescale 1ns/1ps
`default_nettype none

module number_parser (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [7:0]          rx_data,
    input  logic                rx_valid,
    output matrix_pkg::number_t number,
    output logic                number_valid
);

    matrix_pkg::number_t value;
    logic        seen;        // At least one digit since the last separator
    logic [7:0]  digit;
    logic        is_digit;
    logic        is_sep;
    logic [19:0] next_value;  // Holds 65535 * 10 + 9

    assign digit    = rx_data - matrix_pkg::ASCII_ZERO;
    assign is_digit = (rx_data >= matrix_pkg::ASCII_ZERO) && (digit <= 8'd9);
    assign is_sep   = (rx_data == matrix_pkg::ASCII_SPACE) || (rx_data == matrix_pkg::ASCII_COMMA)
                   || (rx_data == matrix_pkg::ASCII_CR) || (rx_data == matrix_pkg::ASCII_LF);
    assign next_value = {4'd0, value} * 20'd10 + {12'd0, digit};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            value        <= '0;
            seen         <= 1'b0;
            number       <= '0;
            number_valid <= 1'b0;
        end else begin
            number_valid <= 1'b0;
            if (rx_valid && is_digit) begin
                seen  <= 1'b1;
                value <= (next_value > 20'hFFFF) ? '1 : next_value[15:0];
            end else if (rx_valid && is_sep) begin
                value <= '0;
                seen  <= 1'b0;
                if (seen) begin
                    number       <= value;
                    number_valid <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/matrix_entry.sv
`timescale 1ns/1ps
`default_nettype none

module matrix_entry (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                mode,        // 1 is display
    input  matrix_pkg::slot_t   slot_sel,
    input  matrix_pkg::number_t number,
    input  logic                number_valid,
    mat_wr_if.writer            wr,
    output logic                err_led
);

    matrix_pkg::entry_state_t state;
    logic              mode_d;
    matrix_pkg::slot_t slot_q;
    matrix_pkg::dim_t  m_q;
    matrix_pkg::dim_t  n_q;
    matrix_pkg::dim_t  row;
    matrix_pkg::dim_t  col;
    logic [4:0]        remaining;  // Elements still expected
    logic              dim_ok;
    logic              num_ok;
    logic [$clog2(matrix_pkg::ERR_HOLD_CYCLES + 1)-1:0] err_cnt;

    assign dim_ok = (number >= 16'd1) && (number <= matrix_pkg::MAX_DIM);
    assign num_ok = (state == matrix_pkg::ENTRY_ELEMS) ? (number <= matrix_pkg::MAX_ELEM) : dim_ok;
    assign err_led = (err_cnt != '0);

    // Slot and dimensions are already stable when the store samples them
    assign wr.slot  = slot_q;
    assign wr.dim_m = m_q;
    assign wr.dim_n = n_q;

    // Address and data of the element taken this cycle
    always_ff @(posedge clk) begin
        wr.row  <= row;
        wr.col  <= col;
        wr.data <= matrix_pkg::elem_t'(number);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= matrix_pkg::ENTRY_ROWS;
            mode_d    <= 1'b0;
            slot_q    <= '0;
            m_q       <= '0;
            n_q       <= '0;
            row       <= '0;
            col       <= '0;
            remaining <= '0;
            err_cnt   <= '0;
            wr.we     <= 1'b0;
            wr.dim_we <= 1'b0;
        end else begin
            mode_d    <= mode;
            wr.we     <= 1'b0;
            wr.dim_we <= 1'b0;
            if (err_cnt != '0) err_cnt <= err_cnt - 1'b1;

            if (mode || (mode != mode_d)) begin
                state <= matrix_pkg::ENTRY_ROWS;  // Numbers in display mode are dropped
            end else if (number_valid && !num_ok) begin
                err_cnt <= matrix_pkg::ERR_HOLD_CYCLES[$bits(err_cnt)-1:0];
            end else if (number_valid) begin
                case (state)
                    matrix_pkg::ENTRY_ROWS: begin
                        m_q    <= number[2:0];
                        slot_q <= slot_sel;
                        state  <= matrix_pkg::ENTRY_COLS;
                    end
                    matrix_pkg::ENTRY_COLS: begin
                        n_q       <= number[2:0];
                        wr.dim_we <= 1'b1;
                        remaining <= m_q * number[2:0];
                        row       <= '0;
                        col       <= '0;
                        state     <= matrix_pkg::ENTRY_ELEMS;
                    end
                    default: begin
                        wr.we     <= 1'b1;
                        remaining <= remaining - 1'b1;
                        if (col == n_q - 1'b1) begin  // Row-major wrap
                            col <= '0;
                            row <= row + 1'b1;
                        end else begin
                            col <= col + 1'b1;
                        end
                        if (remaining == 5'd1) state <= matrix_pkg::ENTRY_ROWS;
                    end
                endcase
            end
        end
    end

    a_we_col: assert property (@(posedge clk) disable iff (!rst_n)
        wr.we |-> (wr.col < n_q));

endmodule

`default_nettype wire

// File: rtl/matrix_store.sv
`timescale 1ns/1ps
`default_nettype none

module matrix_store (
    input  logic     clk,
    input  logic     rst_n,
    mat_wr_if.store  wr,
    mat_rd_if.store  rd
);

    matrix_pkg::elem_t mem [matrix_pkg::NUM_SLOTS][matrix_pkg::MAX_DIM][matrix_pkg::MAX_DIM];
    logic [matrix_pkg::MAX_DIM-1:0][matrix_pkg::MAX_DIM-1:0] written [matrix_pkg::NUM_SLOTS];
    matrix_pkg::dim_t dim_m_q [matrix_pkg::NUM_SLOTS];
    matrix_pkg::dim_t dim_n_q [matrix_pkg::NUM_SLOTS];

    always_ff @(posedge clk) begin
        if (wr.we) mem[wr.slot][wr.row][wr.col] <= wr.data;
    end

    // Per-slot dimensions and written flags
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < matrix_pkg::NUM_SLOTS; s++) begin
                written[s] <= '0;
                dim_m_q[s] <= '0;
                dim_n_q[s] <= '0;
            end
        end else if (wr.dim_we) begin
            written[wr.slot] <= '0;  // New matrix clears its old elements
            dim_m_q[wr.slot] <= wr.dim_m;
            dim_n_q[wr.slot] <= wr.dim_n;
        end else if (wr.we) begin
            written[wr.slot][wr.row][wr.col] <= 1'b1;
        end
    end

    // Unwritten elements read as zero
    always_ff @(posedge clk) begin
        rd.rdata <= written[rd.slot][rd.row][rd.col] ? mem[rd.slot][rd.row][rd.col] : '0;
    end

    assign rd.dim_m = dim_m_q[rd.slot];
    assign rd.dim_n = dim_n_q[rd.slot];

    a_wr_addr: assert property (@(posedge clk) disable iff (!rst_n)
        wr.we |-> (wr.row < matrix_pkg::MAX_DIM) && (wr.col < matrix_pkg::MAX_DIM));

endmodule

`default_nettype wire

// File: rtl/matrix_printer.sv
`timescale 1ns/1ps
`default_nettype none

module matrix_printer (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              mode,
    input  matrix_pkg::slot_t slot_sel,
    input  logic              btn_confirm,
    input  logic              tx_busy,
    mat_rd_if.printer         rd,
    output logic [7:0]        tx_data,
    output logic              tx_start
);

    matrix_pkg::print_state_t state;
    logic              btn_meta;
    logic              btn_sync;
    logic              btn_prev;
    logic              btn_rise;
    logic              tx_ready;
    matrix_pkg::slot_t slot_q;
    matrix_pkg::dim_t  row;
    matrix_pkg::dim_t  col;

    assign btn_rise = btn_sync && !btn_prev;
    assign tx_ready = !tx_busy && !tx_start;  // tx_busy lags tx_start by a cycle

    assign rd.slot = slot_q;
    assign rd.row  = row;
    assign rd.col  = col;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= matrix_pkg::PR_IDLE;
            btn_meta <= 1'b0;
            btn_sync <= 1'b0;
            btn_prev <= 1'b0;
            slot_q   <= '0;
            row      <= '0;
            col      <= '0;
            tx_data  <= '0;
            tx_start <= 1'b0;
        end else begin
            btn_meta <= btn_confirm;
            btn_sync <= btn_meta;
            btn_prev <= btn_sync;
            tx_start <= 1'b0;
            case (state)
                matrix_pkg::PR_IDLE: if (btn_rise && mode) begin
                    slot_q <= slot_sel;
                    row    <= '0;
                    col    <= '0;
                    state  <= matrix_pkg::PR_OPEN;
                end
                matrix_pkg::PR_OPEN: if (tx_ready) begin
                    tx_data  <= matrix_pkg::ASCII_LBRACKET;
                    tx_start <= 1'b1;
                    if (rd.dim_m == '0 || rd.dim_n == '0) state <= matrix_pkg::PR_CLOSE;
                    else state <= matrix_pkg::PR_READ;
                end
                matrix_pkg::PR_READ: state <= matrix_pkg::PR_DIGIT;  // Store read latency
                matrix_pkg::PR_DIGIT: if (tx_ready) begin
                    tx_data  <= matrix_pkg::ASCII_ZERO + {4'd0, rd.rdata};
                    tx_start <= 1'b1;
                    state    <= matrix_pkg::PR_SEP;
                end
                // ------------------------------------------------------------------------
                // Space within a row, line feed between rows
                matrix_pkg::PR_SEP: if (tx_ready) begin
                    if (col != rd.dim_n - 1'b1) begin
                        tx_data  <= matrix_pkg::ASCII_SPACE;
                        tx_start <= 1'b1;
                        col      <= col + 1'b1;
                        state    <= matrix_pkg::PR_READ;
                    end else if (row != rd.dim_m - 1'b1) begin
                        tx_data  <= matrix_pkg::ASCII_LF;
                        tx_start <= 1'b1;
                        row      <= row + 1'b1;
                        col      <= '0;
                        state    <= matrix_pkg::PR_READ;
                    end else begin
                        state <= matrix_pkg::PR_CLOSE;
                    end
                end
                matrix_pkg::PR_CLOSE: if (tx_ready) begin
                    tx_data  <= matrix_pkg::ASCII_RBRACKET;
                    tx_start <= 1'b1;
                    state    <= matrix_pkg::PR_LF;
                end
                matrix_pkg::PR_LF: if (tx_ready) begin
                    tx_data  <= matrix_pkg::ASCII_LF;
                    tx_start <= 1'b1;
                    state    <= matrix_pkg::PR_IDLE;
                end
                default: state <= matrix_pkg::PR_IDLE;
            endcase
        end
    end

    a_start_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(tx_start) |-> !tx_busy);

endmodule

`default_nettype wire

// File: rtl/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] tx_data,
    input  logic       tx_start,
    output logic       txd,
    output logic       tx_busy
);

    logic [9:0] frame;    // Start, data and stop bits leave from bit 0
    logic [3:0] bit_cnt;
    logic [$clog2(matrix_pkg::CLKS_PER_BIT)-1:0] baud_cnt;

    assign txd = frame[0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame    <= '1;  // Idle high
            bit_cnt  <= '0;
            baud_cnt <= '0;
            tx_busy  <= 1'b0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                frame    <= {1'b1, tx_data, 1'b0};
                bit_cnt  <= '0;
                baud_cnt <= '0;
                tx_busy  <= 1'b1;
            end
        end else if (baud_cnt == matrix_pkg::CLKS_PER_BIT - 1) begin
            baud_cnt <= '0;
            frame    <= {1'b1, frame[9:1]};
            bit_cnt  <= bit_cnt + 1'b1;
            if (bit_cnt == 4'd9) tx_busy <= 1'b0;  // End of stop bit
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: rtl/matrix_console.sv
`timescale 1ns/1ps
`default_nettype none

module matrix_console (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              uart_rxd,
    output logic              uart_txd,
    input  logic              mode,        // 0 entry, 1 display
    input  matrix_pkg::slot_t slot_sel,
    input  logic              btn_confirm,
    output logic              err_led
);

    logic [7:0]          rx_data;
    logic                rx_valid;
    matrix_pkg::number_t number;
    logic                number_valid;
    logic [7:0]          tx_data;
    logic                tx_start;
    logic                tx_busy;

    mat_wr_if wr_bus ();
    mat_rd_if rd_bus ();

    // ------------------------------------------------------------------------
    // Input side
    uart_rx u_rx (
        .clk, .rst_n, .rxd(uart_rxd), .rx_data, .rx_valid
    );

    number_parser u_parser (
        .clk, .rst_n, .rx_data, .rx_valid, .number, .number_valid
    );

    matrix_entry u_entry (
        .clk, .rst_n, .mode, .slot_sel, .number, .number_valid,
        .wr(wr_bus.writer), .err_led
    );

    // ------------------------------------------------------------------------
    // Store
    matrix_store u_store (
        .clk, .rst_n, .wr(wr_bus.store), .rd(rd_bus.store)
    );

    // ------------------------------------------------------------------------
    // Output side
    matrix_printer u_printer (
        .clk, .rst_n, .mode, .slot_sel, .btn_confirm, .tx_busy,
        .rd(rd_bus.printer), .tx_data, .tx_start
    );

    uart_tx u_tx (
        .clk, .rst_n, .tx_data, .tx_start, .txd(uart_txd), .tx_busy
    );

endmodule

`default_nettype wire

// File: test/tb_matrix_console.sv
`timescale 1ns/1ps
`default_nettype none

module tb_matrix_console;

    localparam int BIT_CLKS      = matrix_pkg::CLKS_PER_BIT;
    localparam int START_TIMEOUT = 4 * BIT_CLKS;  // Gap before a start bit
    localparam int ERR_TIMEOUT   = 4 * BIT_CLKS;
    localparam int NUM_TESTS     = 7;

    logic              clk;
    logic              rst_n;
    logic              uart_rxd;
    logic              uart_txd;
    logic              mode;
    matrix_pkg::slot_t slot_sel;
    logic              btn_confirm;
    logic              err_led;

    // Stimulus and expected values for each test
    int    tab_slot   [NUM_TESTS];
    string tab_text   [NUM_TESTS];
    string tab_expect [NUM_TESTS];
    bit    tab_err    [NUM_TESTS];

    int rand_vals [25];  // 5x5 random elements in row-major order
    int error_count;
    bit test_bad;

    matrix_console UUT (
        .clk, .rst_n, .uart_rxd, .uart_txd, .mode, .slot_sel, .btn_confirm, .err_led
    );

    always #10 clk = ~clk;

    // ------------------------------------------------------------------------
    // Expected text and readable error output

    // Print format of the random 5x5 matrix
    function automatic string format_random_matrix(input int m, input int n);
        string s;
        int    r;
        int    c;
        s = "[";
        for (r = 0; r < m; r++) begin
            for (c = 0; c < n; c++) begin
                s = $sformatf("%s%0d", s, rand_vals[r * n + c]);
                if (c < n - 1)
                    s = $sformatf("%s ", s);  // Space within a row
                else if (r < m - 1)
                    s = $sformatf("%s\n", s);
            end
        end
        return $sformatf("%s]\n", s);
    endfunction

    function automatic string visible(input string s);
        string r;
        int    k;
        r = "";
        for (k = 0; k < s.len(); k++) begin
            if (s[k] == 8'h0A)
                r = $sformatf("%s\\n", r);
            else if (s[k] == 8'h0D)
                r = $sformatf("%s\\r", r);
            else
                r = $sformatf("%s%c", r, s[k]);
        end
        return r;
    endfunction

    task automatic load_table();
        string text;
        string sep;
        int    k;
        tab_slot[0] = 0;
        tab_err[0] = 0;  // Leading zeros in 005
        tab_text[0] = "2 3 1 0 9 4 005 7 ";
        tab_expect[0] = "[1 0 9\n4 5 7]\n";
        tab_slot[1] = 1;
        tab_err[1] = 0;
        tab_text[1] = "3 1 6 2 8 ";
        tab_expect[1] = "[6\n2\n8]\n";
        tab_slot[2] = 0;
        tab_err[2] = 0;  // Slot 0 untouched by slot 1
        tab_text[2] = "";
        tab_expect[2] = "[1 0 9\n4 5 7]\n";
        tab_slot[3] = 3;
        tab_err[3] = 0;  // Never written
        tab_text[3] = "";
        tab_expect[3] = "[]\n";
        // Random 5x5 with comma and carriage return separators
        text = "5,5\r";
        for (k = 0; k < 25; k++) begin
            rand_vals[k] = $urandom % 10;
            sep = (k % 5 == 4) ? "\r" : ",";
            text = $sformatf("%s%0d%s", text, rand_vals[k], sep);
        end
        tab_slot[4] = 2;
        tab_err[4] = 0;
        tab_text[4] = text;
        tab_expect[4] = format_random_matrix(5, 5);
        tab_slot[5] = 0;
        tab_err[5] = 1;  // Row count out of range
        tab_text[5] = "7 1 1 8 ";
        tab_expect[5] = "[8]\n";
        tab_slot[6] = 1;
        tab_err[6] = 1;  // Element out of range
        tab_text[6] = "2 2 3 12 4 5 6 ";
        tab_expect[6] = "[3 4\n5 6]\n";
    endtask

    // ------------------------------------------------------------------------
    // Reset and serial line tasks

    task automatic apply_reset();
        @(posedge clk);
        #2 rst_n = 1'b0;
        repeat (16) @(posedge clk);
        #2 rst_n = 1'b1;
        repeat (2) @(negedge clk);
        assert (uart_txd === 1'b1) else begin
            $display("** Error at %0t ns: uart_txd = %b, expected 1", $time, uart_txd);
            error_count++;
            test_bad = 1;
        end
        assert (err_led === 1'b0) else begin
            $display("** Error at %0t ns: err_led = %b, expected 0", $time, err_led);
            error_count++;
            test_bad = 1;
        end
    endtask

    // One 8N1 frame with the LSB first
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        int         k;
        frame = {1'b1, b, 1'b0};
        for (k = 0; k < 10; k++) begin
            @(posedge clk);
            #2 uart_rxd = frame[k];
            repeat (BIT_CLKS - 1) @(posedge clk);
        end
    endtask

    task automatic send_text(input string text);
        int k;
        for (k = 0; k < text.len(); k++)
            send_byte(text[k]);
    endtask

    // Collects characters up to the line feed after the closing bracket
    task automatic receive_print(output string text, output bit ok);
        logic [7:0] ch;
        int         wait_cnt;
        int         k;
        bit         seen_close;
        bit         done;
        text       = "";
        ok         = 1;
        seen_close = 0;
        done       = 0;
        while (!done) begin
            wait_cnt = 0;
            @(negedge clk);
            while (uart_txd !== 1'b0 && wait_cnt < START_TIMEOUT) begin
                @(negedge clk);
                wait_cnt++;
            end
            if (uart_txd !== 1'b0) begin
                $display("Timeout at %0t ns: no start bit on uart_txd after \"%s\"",
                         $time, visible(text));
                error_count++;
                test_bad = 1;
                ok   = 0;
                done = 1;
            end else begin
                repeat (BIT_CLKS / 2) @(negedge clk);  // Middle of the start bit
                for (k = 0; k < 8; k++) begin
                    repeat (BIT_CLKS) @(negedge clk);
                    ch[k] = uart_txd;
                end
                repeat (BIT_CLKS) @(negedge clk);
                assert (uart_txd === 1'b1) else begin
                    $display("** Error at %0t ns: uart_txd stop bit = %b, expected 1",
                             $time, uart_txd);
                    error_count++;
                    test_bad = 1;
                end
                text = $sformatf("%s%c", text, ch);
                if (ch == matrix_pkg::ASCII_RBRACKET)
                    seen_close = 1;
                else if (ch == matrix_pkg::ASCII_LF && seen_close)
                    done = 1;
            end
        end
    endtask

    task automatic check_err_led(input bit expected);
        int wait_cnt;
        wait_cnt = 0;
        @(negedge clk);
        while (err_led !== expected && wait_cnt < ERR_TIMEOUT) begin
            @(negedge clk);
            wait_cnt++;
        end
        assert (err_led === expected) else begin
            $display("** Error at %0t ns: err_led = %b, expected %b", $time, err_led, expected);
            error_count++;
            test_bad = 1;
        end
    endtask

    // ------------------------------------------------------------------------
    // Entry, then print of the same slot

    task automatic run_row(input int idx);
        string got;
        bit    ok;
        @(posedge clk);
        #2;
        mode     = 1'b0;
        slot_sel = matrix_pkg::slot_t'(tab_slot[idx]);
        repeat (2) @(posedge clk);
        send_text(tab_text[idx]);
        check_err_led(tab_err[idx]);
        @(posedge clk);
        #2 mode = 1'b1;
        repeat (4) @(posedge clk);
        #2 btn_confirm = 1'b1;
        repeat (3) @(posedge clk);
        #2 btn_confirm = 1'b0;
        receive_print(got, ok);
        if (ok) begin
            assert (got == tab_expect[idx]) else begin
                $display("** Error at %0t ns: uart_txd text = \"%s\", expected \"%s\"",
                         $time, visible(got), visible(tab_expect[idx]));
                error_count++;
                test_bad = 1;
            end
        end
    endtask

    initial begin
        int seed_value;
        int dummy;
        int i;
        int passed;
        int failed;
        clk         = 1'b0;
        rst_n       = 1'b0;
        uart_rxd    = 1'b1;  // Idle line
        mode        = 1'b0;
        slot_sel    = '0;
        btn_confirm = 1'b0;
        error_count = 0;
        passed      = 0;
        failed      = 0;
        seed_value  = 32'ha68c3b9f;
        dummy       = $urandom(seed_value);
        load_table();
        test_bad = 0;
        apply_reset();
        for (i = 0; i < NUM_TESTS; i++) begin
            if (i > 0)
                test_bad = 0;
            if (tab_err[i])
                apply_reset();  // Error hold lasts far longer than one test
            run_row(i);
            if (test_bad)
                failed++;
            else
                passed++;
            $display("Test %0d slot %0d: %s", i + 1, tab_slot[i], test_bad ? "FAIL" : "PASS");
        end
        $display("Tests run %0d, passed %0d, failed %0d, failed checks %0d",
                 NUM_TESTS, passed, failed, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: matrix_console.f
rtl/matrix_pkg.sv
rtl/matrix_ifs.sv
rtl/uart_rx.sv
rtl/number_parser.sv
rtl/matrix_entry.sv
rtl/matrix_store.sv
rtl/matrix_printer.sv
rtl/uart_tx.sv
rtl/matrix_console.sv
test/tb_matrix_console.sv
